//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := execClusterTb
FILELIST  := execCluster.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/execClusterTests.svh
/* Directed tests and op builders, included into the execute cluster
   testbench module */

function automatic op_t aluOp(aluCommand_t cmd, aluSrc1_t src1, aluSrc2_t src2,
                              regAddr_t rs1, regAddr_t rs2, regAddr_t rd, word_t imm);
    op_t op;
    op = '0;
    op.unit = ExecUnit_Alu;
    op.aluCommand = cmd;
    op.aluSrc1 = src1;
    op.aluSrc2 = src2;
    op.rs1 = rs1;
    op.rs2 = rs2;
    op.rd = rd;
    op.regWriteEnable = 1'b1;
    op.imm = imm;
    return op;
endfunction

function automatic op_t loadImm(regAddr_t rd, word_t imm);
    return aluOp(AluCommand_Add, AluSrc1_Zero, AluSrc2_Imm, '0, '0, rd, imm);
endfunction

// rd of x0 means no link register
function automatic op_t branchOp(branchCond_t cond, logic indirect, regAddr_t rs1,
                                 regAddr_t rs2, regAddr_t rd, word_t imm);
    op_t op;
    op = '0;
    op.unit = ExecUnit_Branch;
    op.branchCond = cond;
    op.isIndirect = indirect;
    op.rs1 = rs1;
    op.rs2 = rs2;
    op.rd = rd;
    op.regWriteEnable = rd != '0;
    op.imm = imm;
    return op;
endfunction

// asks for a write to x9, which the trap must suppress
function automatic op_t trapOp(execUnit_t unit, logic isEcall);
    op_t op;
    op = '0;
    op.unit = unit;
    op.isEcall = isEcall;
    op.rd = 5'd9;
    op.regWriteEnable = 1'b1;
    return op;
endfunction

task automatic issuePair(op_t op0, op_t op1);
    bundle_t b;
    b = '0;
    b[0].valid = 1'b1;
    b[0].pc = pcBase;
    b[0].op = op0;
    b[1].valid = 1'b1;
    b[1].pc = pcBase + 4;
    b[1].op = op1;
    pcBase = pcBase + 8;
    issue(b);
endtask

task automatic issueOne(op_t op0);
    bundle_t b;
    b = '0;
    b[0].valid = 1'b1;
    b[0].pc = pcBase;
    b[0].op = op0;
    pcBase = pcBase + 8;
    issue(b);
endtask

task automatic idleCycle();
    issue('0);
endtask

task automatic startTest(string name);
    currentTest = name;
    testStartErrors = errorCount;
    testCount++;
endtask

task automatic endTest();
    drain();
    $display("test %-8s %s, %0d errors", currentTest,
        errorCount == testStartErrors ? "ok" : "FAILED", errorCount - testStartErrors);
endtask

task automatic resetTest();
    regAddr_t r;
    startTest("reset");
    repeat (4) idleCycle();
    for (int i = 1; i < 31; i += 2) begin
        r = regAddr_t'(i);
        issuePair(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, r, '0, r, '0),
            aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, r + 5'd1, '0, r + 5'd1, '0));
    end
    issueOne(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, 5'd31, '0, 5'd31, '0));
    endTest();
endtask

task automatic aluTest();
    aluCommand_t cmd;
    startTest("alu");
    for (int c = 0; c < 12; c++) begin
        cmd = aluCommand_t'(c);
        issuePair(loadImm(5'd1, $urandom()), loadImm(5'd2, $urandom()));
        issuePair(loadImm(5'd3, $urandom()), loadImm(5'd4, $urandom()));
        issuePair(aluOp(cmd, AluSrc1_Reg, AluSrc2_Reg, 5'd1, 5'd2, 5'd10, '0),
            aluOp(cmd, AluSrc1_Reg, AluSrc2_Imm, 5'd3, '0, 5'd11, $urandom()));
        issuePair(aluOp(cmd, AluSrc1_Pc, AluSrc2_Imm, '0, '0, 5'd12, $urandom()),
            aluOp(cmd, AluSrc1_Reg, AluSrc2_Reg, 5'd4, 5'd1, 5'd13, '0));
    end
    endTest();
endtask

task automatic forwardTest();
    regAddr_t cur;
    regAddr_t prev;
    startTest("forward");
    issuePair(loadImm(5'd13, $urandom()), loadImm(5'd14, $urandom()));
    issuePair(loadImm(5'd15, $urandom()), loadImm(5'd16, $urandom()));
    // one source from the bundle just before, one from the bundle before that
    for (int i = 0; i < 8; i++) begin
        cur = regAddr_t'(i % 2);
        prev = regAddr_t'((i + 1) % 2);
        issuePair(aluOp(i % 2 == 1 ? AluCommand_Xor : AluCommand_Add, AluSrc1_Reg,
                AluSrc2_Reg, 5'd13 + prev, 5'd13 + cur, 5'd13 + cur, '0),
            aluOp(AluCommand_Sub, AluSrc1_Reg, AluSrc2_Reg, 5'd15 + prev, 5'd13 + prev,
                5'd15 + cur, '0));
    end
    // x0 takes the commit but keeps reading zero
    issuePair(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd13, '0, '0, 32'd5),
        aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd14, '0, 5'd17, 32'd3));
    issuePair(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, '0, '0, 5'd18, '0),
        aluOp(AluCommand_Or, AluSrc1_Reg, AluSrc2_Reg, '0, 5'd17, 5'd19, '0));
    // same-cycle writes to x20, read from each forwarding source in turn
    issuePair(loadImm(5'd20, 32'd1), loadImm(5'd20, 32'd2));
    issueOne(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd20, '0, 5'd21, '0));
    issueOne(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd20, '0, 5'd22, '0));
    idleCycle();
    issueOne(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd20, '0, 5'd23, '0));
    endTest();
endtask

task automatic branchTest();
    word_t pairA [4];
    word_t pairB [4];
    startTest("branch");
    pairA = '{32'd5, 32'hFFFF_FFFD, 32'd4, $urandom()};
    pairB = '{32'd5, 32'd4, 32'hFFFF_FFFD, $urandom()};
    for (int p = 0; p < 4; p++) begin
        for (int c = 0; c < 6; c++) begin
            issuePair(loadImm(5'd1, pairA[p]), loadImm(5'd2, pairB[p]));
            issuePair(branchOp(branchCond_t'(c), 1'b0, 5'd1, 5'd2, '0, 32'h40),
                loadImm(5'd3, $urandom()));
            // squashed when the branch is taken
            issuePair(loadImm(5'd4, $urandom()), loadImm(5'd5, $urandom()));
            issuePair(loadImm(5'd6, $urandom()),
                aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, 5'd3, 5'd4, 5'd7, '0));
        end
    end
    issuePair(loadImm(5'd6, 32'h0000_2001), loadImm(5'd8, 32'd1));
    issuePair(branchOp(BranchCond_Always, 1'b0, '0, '0, 5'd5, 32'h100), loadImm(5'd9, 32'd2));
    idleCycle();
    idleCycle();
    issuePair(branchOp(BranchCond_Always, 1'b1, 5'd6, '0, 5'd1, 32'h10), loadImm(5'd9, 32'd3));
    idleCycle();
    idleCycle();
    issuePair(branchOp(BranchCond_Always, 1'b1, 5'd5, '0, '0, 32'h3),
        aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Reg, 5'd5, 5'd1, 5'd10, '0));
    endTest();
endtask

task automatic trapCase(op_t trap);
    issuePair(loadImm(5'd8, $urandom()), trap);
    idleCycle();
    idleCycle();
    issueOne(aluOp(AluCommand_Add, AluSrc1_Reg, AluSrc2_Imm, 5'd9, '0, 5'd10, '0));
endtask

task automatic trapTest();
    startTest("trap");
    issueOne(loadImm(5'd9, 32'h1234_5678));
    trapCase(trapOp(ExecUnit_Trap, 1'b1));
    trapCase(trapOp(ExecUnit_Trap, 1'b0));
    trapCase(trapOp(ExecUnit_None, 1'b0));
    endTest();
endtask

//--- bench/execClusterTb.sv
/* Testbench for the execute cluster that issues directed bundles, keeps a shadow
   register model and compares every output cycle at the falling edge */
`default_nettype none

module execClusterTb;
    import rvIsaPkg::*;
    import execPipePkg::*;

    typedef issueSlot_t [NUM_LANES-1:0] bundle_t;

    // outputs expected for one bundle, due at a given falling edge
    typedef struct {
        int due;
        commit_t [NUM_LANES-1:0] commits;
        logic redirect;
        addr_t redirectPc;
        logic trap;
        logic [3:0] cause;
        addr_t value;
    } expect_t;

    logic clk = 1'b0;
    logic rstN;
    bundle_t issueBundle;
    addr_t trapVector;
    commit_t [NUM_LANES-1:0] commitBundle;
    logic redirectValid;
    addr_t redirectPc;
    logic trapValid;
    logic [3:0] trapCause;
    addr_t trapValue;

    word_t shadow [32];
    expect_t pending [$];
    expect_t current;
    int negCount = 0;
    int dropCount = 0;
    addr_t pcBase;
    string currentTest = "reset";
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int testStartErrors = 0;

    execClusterTop i_dut (
        .clk,
        .rstN,
        .issueBundle,
        .trapVector,
        .commitBundle,
        .redirectValid,
        .redirectPc,
        .trapValid,
        .trapCause,
        .trapValue
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic word_t aluRule(aluCommand_t cmd, word_t a, word_t b);
        case (cmd)
            AluCommand_Add:    return a + b;
            AluCommand_Sub:    return a - b;
            AluCommand_Sll:    return a << b[4:0];
            AluCommand_Slt:    return {31'd0, $signed(a) < $signed(b)};
            AluCommand_Sltu:   return {31'd0, a < b};
            AluCommand_Xor:    return a ^ b;
            AluCommand_Srl:    return a >> b[4:0];
            AluCommand_Sra:    return $signed(a) >>> b[4:0];
            AluCommand_Or:     return a | b;
            AluCommand_And:    return a & b;
            AluCommand_Clear1: return a & ~b;
            AluCommand_Clear2: return ~a & b;
            default:           return '0;
        endcase
    endfunction

    function automatic logic branchRule(branchCond_t cond, word_t a, word_t b);
        case (cond)
            BranchCond_Eq:  return a == b;
            BranchCond_Ne:  return a != b;
            BranchCond_Lt:  return $signed(a) < $signed(b);
            BranchCond_Ge:  return $signed(a) >= $signed(b);
            BranchCond_Ltu: return a < b;
            BranchCond_Geu: return a >= b;
            default:        return 1'b1;
        endcase
    endfunction

    function automatic expect_t noOutputs();
        expect_t e;
        e.due = 0;
        e.commits = '0;
        e.redirect = 1'b0;
        e.redirectPc = '0;
        e.trap = 1'b0;
        e.cause = '0;
        e.value = '0;
        return e;
    endfunction

    task automatic checkCommit(int lane, commit_t expected, commit_t actual);
        logic bad;
        checkCount++;
        bad = actual.valid !== expected.valid;
        if (expected.valid) begin
            bad = bad || actual.pc !== expected.pc || actual.rd !== expected.rd ||
                actual.regWriteEnable !== expected.regWriteEnable ||
                (expected.regWriteEnable && actual.value !== expected.value);
        end
        if (bad) begin
            errorCount++;
            $display("CHECK FAILED %s lane %0d: expected %b %h %0d %b %h actual %b %h %0d %b %h",
                currentTest, lane, expected.valid, expected.pc, expected.rd,
                expected.regWriteEnable, expected.value, actual.valid, actual.pc,
                actual.rd, actual.regWriteEnable, actual.value);
        end
    endtask

    task automatic checkRedirect(logic expValid, addr_t expPc);
        checkCount++;
        if (redirectValid !== expValid || (expValid && redirectPc !== expPc)) begin
            errorCount++;
            $display("CHECK FAILED %s redirect: expected %b %h actual %b %h",
                currentTest, expValid, expPc, redirectValid, redirectPc);
        end
    endtask

    task automatic checkTrap(logic expValid, logic [3:0] expCause, addr_t expValue);
        checkCount++;
        if (trapValid !== expValid ||
            (expValid && (trapCause !== expCause || trapValue !== expValue))) begin
            errorCount++;
            $display("CHECK FAILED %s trap: expected %b %0d %h actual %b %0d %h",
                currentTest, expValid, expCause, expValue, trapValid, trapCause, trapValue);
        end
    endtask

    // outputs settle after the rising edge; idle cycles must show no strobes
    always @(negedge clk) begin
        negCount = negCount + 1;
        current = noOutputs();
        if (pending.size() > 0 && pending[0].due == negCount) begin
            current = pending.pop_front();
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            checkCommit(l, current.commits[l], commitBundle[l]);
        end
        checkRedirect(current.redirect, current.redirectPc);
        checkTrap(current.trap, current.cause, current.value);
    end

    // drives one bundle and predicts its outputs three edges later
    task automatic issue(bundle_t bundle);
        expect_t e;
        op_t op;
        addr_t pc;
        word_t a;
        word_t b;
        word_t in1;
        word_t in2;
        e = noOutputs();
        @(posedge clk);
        issueBundle <= bundle;
        e.due = negCount + 4;
        if (dropCount > 0) begin
            dropCount--;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (bundle[l].valid && !e.redirect) begin
                    op = bundle[l].op;
                    pc = bundle[l].pc;
                    a = shadow[op.rs1];
                    b = shadow[op.rs2];
                    in1 = op.aluSrc1 == AluSrc1_Pc ? pc : (op.aluSrc1 == AluSrc1_Reg ? a : '0);
                    in2 = op.aluSrc2 == AluSrc2_Imm ? op.imm : (op.aluSrc2 == AluSrc2_Reg ? b : '0);
                    e.commits[l].valid = 1'b1;
                    e.commits[l].pc = pc;
                    e.commits[l].rd = op.rd;
                    e.commits[l].regWriteEnable = op.regWriteEnable;
                    e.commits[l].value = aluRule(op.aluCommand, in1, in2);
                    if (op.unit == ExecUnit_Branch) begin
                        e.commits[l].value = pc + 4;
                        if (branchRule(op.branchCond, a, b)) begin
                            e.redirect = 1'b1;
                            e.redirectPc = op.isIndirect ? (a + op.imm) & ~32'd1 : pc + op.imm;
                        end
                    end else if (op.unit != ExecUnit_Alu) begin
                        e.commits[l].regWriteEnable = 1'b0;
                        e.redirect = 1'b1;
                        e.redirectPc = trapVector;
                        e.trap = 1'b1;
                        e.value = pc;
                        if (op.unit == ExecUnit_None) begin
                            e.cause = EXC_ILLEGAL_INSN;
                        end else begin
                            e.cause = op.isEcall ? EXC_ECALL_M : EXC_BREAKPOINT;
                        end
                    end
                    if (e.commits[l].regWriteEnable && op.rd != '0) begin
                        shadow[op.rd] = e.commits[l].value;
                    end
                end
            end
            // the bundles in the lanes and in operand read are squashed
            if (e.redirect) begin
                dropCount = 2;
            end
        end
        pending.push_back(e);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        issueBundle <= '0;
        while (pending.size() > 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            $display("timed out in %s: %0d expected output cycles never arrived",
                currentTest, pending.size());
            $display("sim failed");
            $finish;
        end else begin
            dropCount = 0;
        end
    endtask

    `include "execClusterTests.svh"

    initial begin
        void'($urandom(7918));
        rstN = 1'b0;
        issueBundle = '0;
        trapVector = 32'h0000_0800;
        pcBase = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        resetTest();
        aluTest();
        forwardTest();
        branchTest();
        trapTest();

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- execCluster.f
+incdir+bench
verilog/rvIsaPkg.sv
verilog/execPipePkg.sv
verilog/regFile.sv
verilog/regReadStage.sv
verilog/executeLane.sv
verilog/retireStage.sv
verilog/execClusterTop.sv
bench/execClusterTb.sv

//--- verilog/execClusterTop.sv
/* Two-lane integer execute cluster with the register file, the operand read,
   the execute lanes and in-order retire */
`default_nettype none

module execClusterTop (
    input wire logic clk,
    input wire logic rstN,
    input wire execPipePkg::issueSlot_t [execPipePkg::NUM_LANES-1:0] issueBundle,
    input wire rvIsaPkg::addr_t trapVector,
    output execPipePkg::commit_t [execPipePkg::NUM_LANES-1:0] commitBundle,
    output logic redirectValid,
    output rvIsaPkg::addr_t redirectPc,
    output logic trapValid,
    output logic [3:0] trapCause,
    output rvIsaPkg::addr_t trapValue
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    regAddr_t [2*NUM_LANES-1:0] readAddr;
    word_t [2*NUM_LANES-1:0] readData;
    operandSlot_t [NUM_LANES-1:0] operands;
    logic flush;
    logic [NUM_LANES-1:0] writeEnable;
    regAddr_t [NUM_LANES-1:0] writeAddr;
    word_t [NUM_LANES-1:0] writeData;

    // one slice per lane instance
    wire laneResult_t [NUM_LANES-1:0] laneEarly;
    wire laneResult_t [NUM_LANES-1:0] laneResults;

    regFile intRegs (
        .clk,
        .rstN,
        .readAddr,
        .readData,
        .writeEnable,
        .writeAddr,
        .writeData
    );

    regReadStage readStage (
        .clk,
        .rstN,
        .flush,
        .issueBundle,
        .readAddr,
        .readData,
        .laneEarly,
        .laneLate(laneResults),
        .operands
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : gLane
        executeLane lane (
            .clk,
            .rstN,
            .flush,
            .trapVector,
            .operand(operands[l]),
            .early(laneEarly[l]),
            .result(laneResults[l])
        );
    end

    retireStage retire (
        .clk,
        .rstN,
        .laneResults,
        .flush,
        .writeEnable,
        .writeAddr,
        .writeData,
        .commitBundle,
        .redirectValid,
        .redirectPc,
        .trapValid,
        .trapCause,
        .trapValue
    );

endmodule

`default_nettype wire

//--- verilog/execPipePkg.sv
/* Pipeline structs and lane count shared by the execute cluster stages
   and the testbench */
`default_nettype none

package execPipePkg;
    import rvIsaPkg::*;

    localparam int NUM_LANES = 2;

    // none marks an op the decoder could not classify
    typedef enum logic [1:0] {
        ExecUnit_Alu,
        ExecUnit_Branch,
        ExecUnit_Trap,
        ExecUnit_None
    } execUnit_t;

    typedef enum logic [1:0] {
        AluSrc1_Zero,
        AluSrc1_Pc,
        AluSrc1_Reg
    } aluSrc1_t;

    typedef enum logic [1:0] {
        AluSrc2_Zero,
        AluSrc2_Imm,
        AluSrc2_Reg
    } aluSrc2_t;

    typedef struct packed {
        execUnit_t unit;
        aluCommand_t aluCommand;
        aluSrc1_t aluSrc1;
        aluSrc2_t aluSrc2;
        branchCond_t branchCond;
        logic isIndirect;
        logic isEcall;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        logic regWriteEnable;
        word_t imm;
    } op_t;

    // lane 0 is the oldest slot of a bundle
    typedef struct packed {
        logic valid;
        addr_t pc;
        op_t op;
    } issueSlot_t;

    typedef struct packed {
        issueSlot_t slot;
        word_t src1;
        word_t src2;
    } operandSlot_t;

    typedef struct packed {
        logic valid;
        logic [3:0] cause;
        addr_t value;
    } trapInfo_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        regAddr_t rd;
        logic regWriteEnable;
        word_t value;
        logic redirect;
        addr_t redirectPc;
        trapInfo_t trap;
    } laneResult_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        regAddr_t rd;
        logic regWriteEnable;
        word_t value;
    } commit_t;

endpackage

`default_nettype wire

//--- verilog/executeLane.sv
/* One integer execute lane: source muxes, ALU, branch resolution and trap
   detection, with the registered lane result */
`default_nettype none

module executeLane (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flush,
    input wire rvIsaPkg::addr_t trapVector,
    input wire execPipePkg::operandSlot_t operand,
    output execPipePkg::laneResult_t early,
    output execPipePkg::laneResult_t result
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    op_t op;
    addr_t pc;
    word_t aluIn1;
    word_t aluIn2;
    word_t aluOut;
    logic condMet;
    logic branchTaken;
    word_t indirectSum;
    addr_t branchTarget;
    trapInfo_t trap;

    function automatic word_t alu(aluCommand_t command, word_t a, word_t b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (command)
            AluCommand_Add:    return a + b;
            AluCommand_Sub:    return a - b;
            AluCommand_Sll:    return a << shamt;
            AluCommand_Slt:    return word_t'($signed(a) < $signed(b));
            AluCommand_Sltu:   return word_t'(a < b);
            AluCommand_Xor:    return a ^ b;
            AluCommand_Srl:    return a >> shamt;
            AluCommand_Sra:    return word_t'($signed(a) >>> shamt);
            AluCommand_Or:     return a | b;
            AluCommand_And:    return a & b;
            AluCommand_Clear1: return a & ~b;
            AluCommand_Clear2: return ~a & b;
            default:           return '0;
        endcase
    endfunction

    assign op = operand.slot.op;
    assign pc = operand.slot.pc;
    assign aluOut = alu(op.aluCommand, aluIn1, aluIn2);

    always_comb begin
        case (op.aluSrc1)
            AluSrc1_Pc:  aluIn1 = pc;
            AluSrc1_Reg: aluIn1 = operand.src1;
            default:     aluIn1 = '0;
        endcase
        case (op.aluSrc2)
            AluSrc2_Imm: aluIn2 = op.imm;
            AluSrc2_Reg: aluIn2 = operand.src2;
            default:     aluIn2 = '0;
        endcase
    end

    always_comb begin
        case (op.branchCond)
            BranchCond_Eq:  condMet = operand.src1 == operand.src2;
            BranchCond_Ne:  condMet = operand.src1 != operand.src2;
            BranchCond_Lt:  condMet = $signed(operand.src1) < $signed(operand.src2);
            BranchCond_Ge:  condMet = $signed(operand.src1) >= $signed(operand.src2);
            BranchCond_Ltu: condMet = operand.src1 < operand.src2;
            BranchCond_Geu: condMet = operand.src1 >= operand.src2;
            default:        condMet = 1'b1;
        endcase
        branchTaken = operand.slot.valid && op.unit == ExecUnit_Branch && condMet;

        // jalr drops bit 0 of the target
        indirectSum = operand.src1 + op.imm;
        if (op.isIndirect) begin
            branchTarget = {indirectSum[XLEN-1:1], 1'b0};
        end else begin
            branchTarget = pc + op.imm;
        end
    end

    always_comb begin
        trap = '0;
        if (operand.slot.valid && op.unit == ExecUnit_Trap) begin
            trap.valid = 1'b1;
            trap.cause = op.isEcall ? EXC_ECALL_M : EXC_BREAKPOINT;
            trap.value = pc;
        end else if (operand.slot.valid && op.unit == ExecUnit_None) begin
            trap.valid = 1'b1;
            trap.cause = EXC_ILLEGAL_INSN;
            trap.value = pc;
        end
    end

    always_comb begin
        early.valid = operand.slot.valid;
        early.pc = pc;
        early.rd = op.rd;
        early.regWriteEnable = op.regWriteEnable && !trap.valid;
        // link value for jumps
        early.value = (op.unit == ExecUnit_Branch) ? pc + 32'd4 : aluOut;
        early.redirect = branchTaken || trap.valid;
        early.redirectPc = trap.valid ? trapVector : branchTarget;
        early.trap = trap;
    end

    always_ff @(posedge clk) begin
        result <= early;
        if (!rstN || flush) begin
            result.valid <= 1'b0;
        end
    end

    takenBranchNeverTraps: assert property (
        @(posedge clk) disable iff (!rstN) branchTaken |=> !(result.valid && result.trap.valid)
    ) else $error("lane result carries both a taken branch and a trap");

endmodule

`default_nettype wire

//--- verilog/regFile.sv
/* Integer register file with x0 tied to zero, two combinational read
   ports and one write port per lane */
`default_nettype none

module regFile (
    input wire logic clk,
    input wire logic rstN,
    input wire rvIsaPkg::regAddr_t [2*execPipePkg::NUM_LANES-1:0] readAddr,
    output rvIsaPkg::word_t [2*execPipePkg::NUM_LANES-1:0] readData,
    input wire logic [execPipePkg::NUM_LANES-1:0] writeEnable,
    input wire rvIsaPkg::regAddr_t [execPipePkg::NUM_LANES-1:0] writeAddr,
    input wire rvIsaPkg::word_t [execPipePkg::NUM_LANES-1:0] writeData
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    word_t regs [1:31];

    // higher lane is written last and wins a clash
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (writeEnable[l] && writeAddr[l] != '0) begin
                    regs[writeAddr[l]] <= writeData[l];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2 * NUM_LANES; p++) begin
            if (readAddr[p] == '0) begin
                readData[p] = '0;
            end else begin
                readData[p] = regs[readAddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/regReadStage.sv
/* Operand read for one issue bundle with forwarding from the two bundles
   still in the lanes, registered into the operand bundle */
`default_nettype none

module regReadStage (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flush,
    input wire execPipePkg::issueSlot_t [execPipePkg::NUM_LANES-1:0] issueBundle,
    output rvIsaPkg::regAddr_t [2*execPipePkg::NUM_LANES-1:0] readAddr,
    input wire rvIsaPkg::word_t [2*execPipePkg::NUM_LANES-1:0] readData,
    input wire execPipePkg::laneResult_t [execPipePkg::NUM_LANES-1:0] laneEarly,
    input wire execPipePkg::laneResult_t [execPipePkg::NUM_LANES-1:0] laneLate,
    output execPipePkg::operandSlot_t [execPipePkg::NUM_LANES-1:0] operands
);
    import rvIsaPkg::*;
    import execPipePkg::*;

    operandSlot_t [NUM_LANES-1:0] nextOperands;
    logic intraBundleHazard;

    function automatic logic writesReg(laneResult_t r, regAddr_t src);
        return r.valid && r.regWriteEnable && r.rd == src;
    endfunction

    // youngest source last so it overrides; higher lane overrides lower
    function automatic word_t forwardValue(regAddr_t src, word_t fileValue);
        word_t value;
        value = fileValue;
        if (src != '0) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (writesReg(laneLate[l], src)) begin
                    value = laneLate[l].value;
                end
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (writesReg(laneEarly[l], src)) begin
                    value = laneEarly[l].value;
                end
            end
        end
        return value;
    endfunction

    function automatic logic readsRs1(op_t op);
        return (op.unit == ExecUnit_Alu && op.aluSrc1 == AluSrc1_Reg) ||
            (op.unit == ExecUnit_Branch &&
            (op.branchCond != BranchCond_Always || op.isIndirect));
    endfunction

    function automatic logic readsRs2(op_t op);
        return (op.unit == ExecUnit_Alu && op.aluSrc2 == AluSrc2_Reg) ||
            (op.unit == ExecUnit_Branch && op.branchCond != BranchCond_Always);
    endfunction

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            readAddr[2*l] = issueBundle[l].op.rs1;
            readAddr[2*l+1] = issueBundle[l].op.rs2;
            nextOperands[l].slot = issueBundle[l];
            nextOperands[l].src1 = forwardValue(issueBundle[l].op.rs1, readData[2*l]);
            nextOperands[l].src2 = forwardValue(issueBundle[l].op.rs2, readData[2*l+1]);
        end
    end

    // same-bundle dependencies are split by the decoder, never forwarded here
    always_comb begin
        intraBundleHazard = 1'b0;
        for (int l = 1; l < NUM_LANES; l++) begin
            for (int k = 0; k < l; k++) begin
                if (issueBundle[l].valid && issueBundle[k].valid &&
                    issueBundle[k].op.regWriteEnable && issueBundle[k].op.rd != '0) begin
                    if ((readsRs1(issueBundle[l].op) &&
                         issueBundle[l].op.rs1 == issueBundle[k].op.rd) ||
                        (readsRs2(issueBundle[l].op) &&
                         issueBundle[l].op.rs2 == issueBundle[k].op.rd)) begin
                        intraBundleHazard = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        operands <= nextOperands;
        if (!rstN || flush) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                operands[l].slot.valid <= 1'b0;
            end
        end
    end

    noIntraBundleDependency: assert property (
        @(posedge clk) disable iff (!rstN) !intraBundleHazard
    ) else $error("issue bundle reads a register written by an older lane");

endmodule

`default_nettype wire

//--- verilog/retireStage.sv
/* In-order retire of the lane results that commits up to the first redirect,
   writes the register file and reports redirects and traps */
`default_nettype none

module retireStage (
    input wire logic clk,
    input wire logic rstN,
    input wire execPipePkg::laneResult_t [execPipePkg::NUM_LANES-1:0] laneResults,
    output logic flush,
    output logic [execPipePkg::NUM_LANES-1:0] writeEnable,
    output rvIsaPkg::regAddr_t [execPipePkg::NUM_LANES-1:0] writeAddr,
    output rvIsaPkg::word_t [execPipePkg::NUM_LANES-1:0] writeData,
    output execPipePkg::commit_t [execPipePkg::NUM_LANES-1:0] commitBundle,
    output logic redirectValid,
    output rvIsaPkg::addr_t redirectPc,
    output logic trapValid,
    output logic [3:0] trapCause,
    output rvIsaPkg::addr_t trapValue
);
    import execPipePkg::*;

    logic [NUM_LANES-1:0] commitMask;
    laneResult_t redirectLane;
    commit_t [NUM_LANES-1:0] nextCommit;
    logic trapWithoutRedirect;

    // lowest redirecting lane still commits and every lane above it is dropped
    always_comb begin
        flush = 1'b0;
        redirectLane = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            commitMask[l] = laneResults[l].valid && !flush;
            if (commitMask[l] && laneResults[l].redirect) begin
                flush = 1'b1;
                redirectLane = laneResults[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            writeEnable[l] = commitMask[l] && laneResults[l].regWriteEnable;
            writeAddr[l] = laneResults[l].rd;
            writeData[l] = laneResults[l].value;

            nextCommit[l].valid = commitMask[l];
            nextCommit[l].pc = laneResults[l].pc;
            nextCommit[l].rd = laneResults[l].rd;
            nextCommit[l].regWriteEnable = laneResults[l].regWriteEnable;
            nextCommit[l].value = laneResults[l].value;
        end
    end

    // retire reports a trap only through the redirect of its lane
    always_comb begin
        trapWithoutRedirect = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (laneResults[l].valid && laneResults[l].trap.valid &&
                !laneResults[l].redirect) begin
                trapWithoutRedirect = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        commitBundle <= nextCommit;
        redirectPc <= redirectLane.redirectPc;
        trapCause <= redirectLane.trap.cause;
        trapValue <= redirectLane.trap.value;
        if (!rstN) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                commitBundle[l].valid <= 1'b0;
            end
            redirectValid <= 1'b0;
            trapValid <= 1'b0;
        end else begin
            redirectValid <= flush;
            trapValid <= flush && redirectLane.trap.valid;
        end
    end

    trapImpliesRedirect: assert property (
        @(posedge clk) disable iff (!rstN) !trapWithoutRedirect
    ) else $error("lane result carries a trap without a redirect");

endmodule

`default_nettype wire

//--- verilog/rvIsaPkg.sv
/* RV32I types, ALU and branch encodings and trap causes used by the
   integer execute cluster and its testbench */
`default_nettype none

package rvIsaPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0] regAddr_t;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And,
        AluCommand_Clear1,
        AluCommand_Clear2
    } aluCommand_t;

    // always covers jal and jalr
    typedef enum logic [2:0] {
        BranchCond_Eq,
        BranchCond_Ne,
        BranchCond_Lt,
        BranchCond_Ge,
        BranchCond_Ltu,
        BranchCond_Geu,
        BranchCond_Always
    } branchCond_t;

    // machine-mode exception codes
    localparam logic [3:0] EXC_ILLEGAL_INSN = 4'd2;
    localparam logic [3:0] EXC_BREAKPOINT = 4'd3;
    localparam logic [3:0] EXC_ECALL_M = 4'd11;

endpackage

`default_nettype wire
